// File: hw/rv_core_config.svh
// rv core configuration: data and pc widths, memory depths and the apb address map
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// data and instruction word width
`define RV_XLEN 32

// byte program counter width, wraps at 256 bytes
`define RV_PC_W 8

// memory sizes in 32-bit words
`define RV_IMEM_DEPTH 64
`define RV_DMEM_DEPTH 64

// apb address width
`define RV_APB_AW 12

// apb base addresses
`define RV_MAP_CTRL   12'h000
`define RV_MAP_STATUS 12'h004
`define RV_MAP_IMEM   12'h100
`define RV_MAP_DMEM   12'h200
`define RV_MAP_REGS   12'h300

`endif

// File: hw/rv_core_pkg.sv
// rv core package: vector types, opcode encoding and the structs passed between blocks
`include "rv_core_config.svh"

package rv_core_pkg;

    // plain vectors with a meaning
    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_PC_W-1:0] pc_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [$clog2(`RV_IMEM_DEPTH)-1:0] mem_idx_t;

    // supported major opcodes, everything else halts
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // fetch to if/id
    typedef struct packed {
        word_t instr;
        pc_t   pc;
    } fetch_t;

    // if/id to execute
    // raw opcode bits so undefined encodings survive to decode
    typedef struct packed {
        logic       valid;
        logic [6:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      instr;
        pc_t        pc;
    } dec_t;

    // taken branch back to fetch
    typedef struct packed {
        logic taken;
        pc_t  target;
    } redirect_t;

    // apb side memory port
    typedef struct packed {
        logic     we;
        mem_idx_t idx;
        word_t    wdata;
    } mem_acc_t;

    // apb request and response
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [`RV_APB_AW-1:0] paddr;
        word_t                 pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// File: hw/fetch_unit.sv
// fetch unit: program counter, instruction memory and branch redirect
`timescale 1ns/100ps
`include "rv_core_config.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  logic                   start,
    input  rv_core_pkg::redirect_t redirect,
    input  rv_core_pkg::mem_acc_t  imem_acc,
    output rv_core_pkg::word_t     imem_rdata,
    output rv_core_pkg::fetch_t    fetch
);
    import rv_core_pkg::*;

    // byte pc, low two bits always zero in practice
    pc_t pc_q;

    // instruction store, loaded over apb while stopped
    word_t imem [`RV_IMEM_DEPTH];

    // single read port shared between fetch and apb
    mem_idx_t rd_idx;
    word_t    rd_word;

    // pc update
    // start wins so a restart always begins at word 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (start) begin
            pc_q <= '0;
        end else if (run) begin
            if (redirect.taken) begin
                // taken beq from execute
                pc_q <= redirect.target;
            end else begin
                // sequential, wraps at 8 bits
                pc_q <= pc_q + pc_t'(4);
            end
        end
    end

    // apb load of the program
    always_ff @(posedge clk) begin
        if (imem_acc.we) begin
            imem[imem_acc.idx] <= imem_acc.wdata;
        end
    end

    // word index from pc while running, apb index otherwise
    assign rd_idx = run ? pc_q[`RV_PC_W-1:2] : imem_acc.idx;

    // combinational read
    assign rd_word = imem[rd_idx];

    // apb readback path
    assign imem_rdata = rd_word;

    // instruction and its pc to if/id
    assign fetch.instr = rd_word;
    assign fetch.pc    = pc_q;

endmodule

// File: hw/if_id.sv
// if/id pipeline register: holds instruction and pc, slices the decode fields
`timescale 1ns/100ps

module if_id (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                write_en,
    input  logic                flush,
    input  rv_core_pkg::fetch_t fetch,
    output rv_core_pkg::dec_t   dec
);
    import rv_core_pkg::*;

    // slot valid, the only control bit here
    logic valid_q;

    // payload, captured on write_en
    logic [6:0] opcode_q;
    reg_idx_t   rd_q;
    reg_idx_t   rs1_q;
    reg_idx_t   rs2_q;
    word_t      instr_q;
    pc_t        pc_q;

    // flush clears the slot even while write_en is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (write_en) begin
            valid_q <= 1'b1;
        end
    end

    // field slicing at capture time
    // funct3 is not decoded, funct7 comes from instr
    always_ff @(posedge clk) begin
        if (write_en) begin
            instr_q  <= fetch.instr;
            pc_q     <= fetch.pc;
            opcode_q <= fetch.instr[6:0];
            rd_q     <= fetch.instr[11:7];
            rs1_q    <= fetch.instr[19:15];
            rs2_q    <= fetch.instr[24:20];
        end
    end

    // registered view for execute
    assign dec = '{valid: valid_q, opcode: opcode_q, rd: rd_q, rs1: rs1_q,
                   rs2: rs2_q, instr: instr_q, pc: pc_q};

endmodule

// File: hw/exec_unit.sv
// execute unit: decode, register file, alu, data memory, branch resolve and halt
`timescale 1ns/100ps
`include "rv_core_config.svh"

module exec_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  rv_core_pkg::dec_t      dec,
    input  rv_core_pkg::mem_acc_t  dmem_acc,
    input  rv_core_pkg::reg_idx_t  reg_idx,
    output rv_core_pkg::word_t     dmem_rdata,
    output rv_core_pkg::word_t     reg_rdata,
    output rv_core_pkg::redirect_t redirect,
    output logic                   halt,
    output rv_core_pkg::pc_t       halt_pc
);
    import rv_core_pkg::*;

    // architectural state
    word_t rf [32];
    word_t dmem [`RV_DMEM_DEPTH];

    // decode
    opcode_e op;
    logic    active;
    logic    rf_we;
    logic    dm_we;
    logic    is_beq;
    logic    illegal;

    // operands and immediates
    word_t rs1_val;
    word_t rs2_val;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;

    // results
    word_t    eff_addr;
    mem_idx_t dm_idx;
    word_t    dm_word;
    word_t    wb_data;

    // only a valid slot executes, and only while running
    assign active = run & dec.valid;
    assign op     = opcode_e'(dec.opcode);

    // x0 reads as zero
    assign rs1_val = (dec.rs1 == '0) ? '0 : rf[dec.rs1];
    assign rs2_val = (dec.rs2 == '0) ? '0 : rf[dec.rs2];

    // sign extended immediates
    assign imm_i = {{20{dec.instr[31]}}, dec.instr[31:20]};
    assign imm_s = {{20{dec.instr[31]}}, dec.instr[31:25], dec.instr[11:7]};
    assign imm_b = {{19{dec.instr[31]}}, dec.instr[31], dec.instr[7],
                    dec.instr[30:25], dec.instr[11:8], 1'b0};

    // load and store address, word aligned
    assign eff_addr = rs1_val + ((op == OP_STORE) ? imm_s : imm_i);

    // one data memory read port, apb index while stopped
    assign dm_idx     = run ? eff_addr[7:2] : dmem_acc.idx;
    assign dm_word    = dmem[dm_idx];
    assign dmem_rdata = dm_word;

    // main decode
    always_comb begin
        rf_we   = 1'b0;
        dm_we   = 1'b0;
        is_beq  = 1'b0;
        illegal = 1'b0;
        wb_data = '0;
        case (op)
            OP_R: begin
                // bit 30 picks sub over add
                rf_we   = 1'b1;
                wb_data = dec.instr[30] ? (rs1_val - rs2_val) : (rs1_val + rs2_val);
            end
            OP_IMM: begin
                rf_we   = 1'b1;
                wb_data = rs1_val + imm_i;
            end
            OP_LOAD: begin
                rf_we   = 1'b1;
                wb_data = dm_word;
            end
            OP_STORE: begin
                dm_we = 1'b1;
            end
            OP_BRANCH: begin
                is_beq = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // writeback, x0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (active && rf_we && dec.rd != '0) begin
            rf[dec.rd] <= wb_data;
        end
    end

    // sw from the core, apb load while stopped
    always_ff @(posedge clk) begin
        if (active && dm_we) begin
            dmem[eff_addr[7:2]] <= rs2_val;
        end else if (dmem_acc.we) begin
            dmem[dmem_acc.idx] <= dmem_acc.wdata;
        end
    end

    // apb register readback
    assign reg_rdata = (reg_idx == '0) ? '0 : rf[reg_idx];

    // beq resolves here, one bubble behind it
    assign redirect.taken  = active & is_beq & (rs1_val == rs2_val);
    assign redirect.target = dec.pc + imm_b[`RV_PC_W-1:0];

    // undefined opcode stops the core, pc latched in apb_ctrl
    assign halt    = active & illegal;
    assign halt_pc = dec.pc;

endmodule

// File: hw/apb_ctrl.sv
// apb slave: register map decode, run and halt state, memory access routing
`timescale 1ns/100ps
`include "rv_core_config.svh"

module apb_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::apb_req_t apb_req,
    input  logic                  halt,
    input  rv_core_pkg::pc_t      halt_pc,
    input  rv_core_pkg::word_t    imem_rdata,
    input  rv_core_pkg::word_t    dmem_rdata,
    input  rv_core_pkg::word_t    reg_rdata,
    output rv_core_pkg::apb_rsp_t apb_rsp,
    output logic                  run,
    output logic                  start,
    output rv_core_pkg::mem_acc_t imem_acc,
    output rv_core_pkg::mem_acc_t dmem_acc,
    output rv_core_pkg::reg_idx_t reg_idx
);
    import rv_core_pkg::*;

    // 256 byte pages, regs use the lower half of theirs
    localparam logic [`RV_APB_AW-1:0] PAGE_MASK = 12'hf00;
    localparam logic [`RV_APB_AW-1:0] REGS_MASK = 12'hf80;

    logic  access;
    logic  wr;
    logic  sel_ctrl;
    logic  sel_status;
    logic  sel_imem;
    logic  sel_dmem;
    logic  sel_regs;
    logic  err;
    logic  start_req;
    logic  halted;
    pc_t   halt_pc_q;
    word_t rdata;

    // access phase only, no wait states
    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite;

    // address map
    assign sel_ctrl   = apb_req.paddr == `RV_MAP_CTRL;
    assign sel_status = apb_req.paddr == `RV_MAP_STATUS;
    assign sel_imem   = (apb_req.paddr & PAGE_MASK) == `RV_MAP_IMEM;
    assign sel_dmem   = (apb_req.paddr & PAGE_MASK) == `RV_MAP_DMEM;
    assign sel_regs   = (apb_req.paddr & REGS_MASK) == `RV_MAP_REGS;

    // read mux and error check
    always_comb begin
        err   = 1'b0;
        rdata = '0;
        if (sel_ctrl) begin
            rdata[0] = run;
        end else if (sel_status) begin
            rdata[0]    = halted;
            rdata[15:8] = halt_pc_q;
        end else if (sel_imem) begin
            // memories belong to the core while running
            err   = run;
            rdata = imem_rdata;
        end else if (sel_dmem) begin
            err   = run;
            rdata = dmem_rdata;
        end else if (sel_regs) begin
            err   = apb_req.pwrite;
            rdata = reg_rdata;
        end else begin
            err = 1'b1;
        end
        if (err) begin
            rdata = '0;
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & err;

    // memory strobes, blocked while running
    assign imem_acc.we    = wr & sel_imem & ~run;
    assign imem_acc.idx   = apb_req.paddr[7:2];
    assign imem_acc.wdata = apb_req.pwdata;
    assign dmem_acc.we    = wr & sel_dmem & ~run;
    assign dmem_acc.idx   = apb_req.paddr[7:2];
    assign dmem_acc.wdata = apb_req.pwdata;
    assign reg_idx        = apb_req.paddr[6:2];

    // ctrl write of 1 from the stopped state
    assign start_req = wr & sel_ctrl & apb_req.pwdata[0] & ~run;

    // run rises the cycle after start, once pc and if/id are cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run       <= 1'b0;
            start     <= 1'b0;
            halted    <= 1'b0;
            halt_pc_q <= '0;
        end else begin
            start <= start_req;
            if (start_req) begin
                halted <= 1'b0;
            end
            if (start) begin
                run <= 1'b1;
            end else if (halt) begin
                run       <= 1'b0;
                halted    <= 1'b1;
                halt_pc_q <= halt_pc;
            end
        end
    end

endmodule

// File: hw/rv_core_top.sv
// rv core top: fetch, if/id, execute and the apb control slave
`timescale 1ns/100ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::apb_req_t apb_req,
    output rv_core_pkg::apb_rsp_t apb_rsp
);
    import rv_core_pkg::*;

    // control from the apb slave
    logic     run;
    logic     start;
    mem_acc_t imem_acc;
    mem_acc_t dmem_acc;
    reg_idx_t reg_idx;

    // readback into the apb slave
    word_t imem_rdata;
    word_t dmem_rdata;
    word_t reg_rdata;

    // pipeline
    fetch_t    fetch;
    dec_t      dec;
    redirect_t redirect;
    logic      flush;

    // halt report from execute
    logic halt;
    pc_t  halt_pc;

    // restart or taken beq drops the fetched instruction
    assign flush = start | redirect.taken;

    fetch_unit i_fetch_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .start      (start),
        .redirect   (redirect),
        .imem_acc   (imem_acc),
        .imem_rdata (imem_rdata),
        .fetch      (fetch)
    );

    // stalls exactly while run is low
    if_id i_if_id (
        .clk      (clk),
        .rst_n    (rst_n),
        .write_en (run),
        .flush    (flush),
        .fetch    (fetch),
        .dec      (dec)
    );

    exec_unit i_exec_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .dec        (dec),
        .dmem_acc   (dmem_acc),
        .reg_idx    (reg_idx),
        .dmem_rdata (dmem_rdata),
        .reg_rdata  (reg_rdata),
        .redirect   (redirect),
        .halt       (halt),
        .halt_pc    (halt_pc)
    );

    apb_ctrl i_apb_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .halt       (halt),
        .halt_pc    (halt_pc),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata),
        .reg_rdata  (reg_rdata),
        .apb_rsp    (apb_rsp),
        .run        (run),
        .start      (start),
        .imem_acc   (imem_acc),
        .dmem_acc   (dmem_acc),
        .reg_idx    (reg_idx)
    );

endmodule

// File: dv/rv_core_properties.sv
// rv core assertions: if/id hold and flush behavior, apb error timing
`timescale 1ns/100ps

module rv_core_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  write_en,
    input logic                  flush,
    input rv_core_pkg::dec_t     dec,
    input rv_core_pkg::apb_req_t apb_req,
    input rv_core_pkg::apb_rsp_t apb_rsp
);
    import rv_core_pkg::*;

    // slave error only in the access phase
    assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr raised outside the apb access phase");

    // payload frozen while the write enable is low
    assert property (@(posedge clk) disable iff (!rst_n)
        !write_en |=> ($stable(dec.instr) && $stable(dec.pc)))
        else $error("if/id payload changed while write_en was low");

    // flushed slot comes back empty
    assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !dec.valid)
        else $error("if/id valid set in the cycle after a flush");

endmodule

// pipeline and apb signals all meet in the top level
bind rv_core_top rv_core_properties i_rv_core_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .write_en (run),
    .flush    (flush),
    .dec      (dec),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp)
);

// File: dv/rv_core_tb.sv
// rv core testbench: apb program loading, instruction-set reference model and readback checks
`timescale 1ns/100ps
`include "rv_core_config.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // program image and model state, the model rf mirrors the dut across tests
    word_t prog [64];
    word_t m_rf [32];
    word_t m_dmem [64];
    int    errors;
    int    checks;
    int    tests;

    rv_core_top i_rv_core_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #20 clk = ~clk;

    // instruction encoders
    function automatic word_t enc_r(logic sub, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                    logic [2:0] f3);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t enc_i(logic [6:0] opc, reg_idx_t rd, reg_idx_t rs1,
                                    logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, opc};
    endfunction

    function automatic word_t enc_s(reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(reg_idx_t rs1, reg_idx_t rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63};
    endfunction

    // reference interpreter, updates m_rf and m_dmem and returns the halt pc
    function automatic pc_t run_model();
        pc_t   pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t addr;
        word_t res;
        logic  wb;
        pc = '0;
        for (int step = 0; step < 20000; step++) begin
            ins  = prog[pc[7:2]];
            a    = m_rf[ins[19:15]];
            b    = m_rf[ins[24:20]];
            wb   = 1'b0;
            res  = '0;
            case (ins[6:0])
                OP_R: begin
                    wb  = 1'b1;
                    res = ins[30] ? a - b : a + b;
                end
                OP_IMM: begin
                    wb  = 1'b1;
                    res = a + {{20{ins[31]}}, ins[31:20]};
                end
                OP_LOAD: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    wb   = 1'b1;
                    res  = m_dmem[addr[7:2]];
                end
                OP_STORE: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    m_dmem[addr[7:2]] = b;
                end
                OP_BRANCH: begin
                    // taken target replaces the sequential step below
                    if (a == b) begin
                        pc = pc + {ins[7], ins[30:25], ins[11:8], 1'b0} - pc_t'(4);
                    end
                end
                default: begin
                    return pc;
                end
            endcase
            if (wb && ins[11:7] != 5'd0) begin
                m_rf[ins[11:7]] = res;
            end
            pc = pc + pc_t'(4);
        end
        $display("reference model never reached an undefined opcode");
        errors++;
        return '0;
    endfunction

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $finish;
    endtask

    task automatic check(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // one apb transfer, setup then access phase
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input word_t wdata,
                            output word_t rdata, output logic err);
        int n;
        n = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!apb_rsp.pready) begin
            abort("apb slave never raised pready");
        end else begin
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
            @(posedge clk);
            apb_req <= '0;
        end
    endtask

    task automatic load_program();
        word_t rd;
        logic  err;
        for (int i = 0; i < 64; i++) begin
            apb_xfer(1'b1, `RV_MAP_IMEM + 12'(i * 4), prog[i], rd, err);
            check("imem pslverr", 32'd0, {31'd0, err});
        end
    endtask

    task automatic compare_regs(input string tag);
        word_t rd;
        logic  err;
        for (int i = 0; i < 32; i++) begin
            apb_xfer(1'b0, `RV_MAP_REGS + 12'(i * 4), '0, rd, err);
            check($sformatf("%s x%0d", tag, i), m_rf[i], rd);
        end
    endtask

    task automatic compare_dmem(input string tag);
        word_t rd;
        logic  err;
        for (int i = 0; i < 64; i++) begin
            apb_xfer(1'b0, `RV_MAP_DMEM + 12'(i * 4), '0, rd, err);
            check($sformatf("%s dmem[%0d]", tag, i), m_dmem[i], rd);
        end
    endtask

    task automatic start_core();
        word_t rd;
        logic  err;
        apb_xfer(1'b1, `RV_MAP_CTRL, 32'd1, rd, err);
        check("ctrl pslverr", 32'd0, {31'd0, err});
    endtask

    // poll status until halted, then compare the halt pc
    task automatic wait_halt(input pc_t exp_pc);
        word_t st;
        logic  err;
        int    n;
        n  = 0;
        st = '0;
        while (!st[0] && n < 4000) begin
            apb_xfer(1'b0, `RV_MAP_STATUS, '0, st, err);
            n++;
        end
        if (!st[0]) begin
            abort("core did not halt within the poll limit");
        end else begin
            check("status halt_pc", {24'd0, exp_pc}, {24'd0, st[15:8]});
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, errors - err_before);
        end
    endtask

    // x5 counts down from n, x6 counts trips, x7 sits behind a taken beq
    task automatic build_countdown(input logic [11:0] n);
        prog    = '{default: '0};
        prog[0] = enc_i(OP_IMM, 5'd5, 5'd0, n);
        prog[1] = enc_i(OP_IMM, 5'd6, 5'd0, 12'd0);
        prog[2] = enc_i(OP_IMM, 5'd5, 5'd5, 12'hfff);
        prog[3] = enc_i(OP_IMM, 5'd6, 5'd6, 12'd1);
        prog[4] = enc_b(5'd5, 5'd0, 13'd12);
        prog[5] = enc_b(5'd0, 5'd0, -13'sd12);
        prog[6] = enc_i(OP_IMM, 5'd7, 5'd7, 12'd1);
    endtask

    initial begin
        word_t r;
        word_t rd;
        logic  err;
        pc_t   hpc;
        int    e0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        m_rf    = '{default: '0};
        void'($urandom(8382));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // arithmetic, random rd includes x0, funct3 is noise
        e0   = errors;
        prog = '{default: '0};
        for (int i = 0; i < 24; i++) begin
            r = $urandom();
            if (r[1:0] == 2'd0) begin
                prog[i] = enc_r(r[2], {2'd0, r[5:3]}, {2'd0, r[8:6]}, {2'd0, r[11:9]},
                                r[14:12]);
            end else begin
                prog[i] = enc_i(OP_IMM, {2'd0, r[5:3]}, {2'd0, r[8:6]}, r[31:20]);
            end
        end
        load_program();
        hpc = run_model();
        start_core();
        wait_halt(hpc);
        compare_regs("arith");
        end_test("arithmetic", e0);

        // memory, random data image then mixed sw and lw
        e0 = errors;
        for (int i = 0; i < 64; i++) begin
            m_dmem[i] = $urandom();
            apb_xfer(1'b1, `RV_MAP_DMEM + 12'(i * 4), m_dmem[i], rd, err);
        end
        prog = '{default: '0};
        for (int i = 0; i < 4; i++) begin
            r       = $urandom();
            prog[i] = enc_i(OP_IMM, reg_idx_t'(i + 1), 5'd0, r[11:0]);
        end
        for (int i = 4; i < 32; i++) begin
            r = $urandom();
            if (r[0]) begin
                prog[i] = enc_s({3'd0, r[2:1]}, {2'd0, r[5:3]}, {r[15:6], 2'b00});
            end else begin
                prog[i] = enc_i(OP_LOAD, {2'd0, r[5:3]}, {3'd0, r[2:1]}, {r[15:6], 2'b00});
            end
        end
        load_program();
        hpc = run_model();
        start_core();
        wait_halt(hpc);
        compare_dmem("mem");
        compare_regs("mem");
        end_test("memory", e0);

        // branches, countdown of 10 trips
        e0 = errors;
        build_countdown(12'd10);
        load_program();
        hpc = run_model();
        start_core();
        wait_halt(hpc);
        compare_regs("branch");
        // trip counter x6 straight from the core
        apb_xfer(1'b0, `RV_MAP_REGS + 12'h018, '0, rd, err);
        check("trip count x6", 32'd10, rd);
        end_test("branches", e0);

        // halt on an undefined opcode at word 3
        e0      = errors;
        prog    = '{default: '0};
        prog[0] = enc_i(OP_IMM, 5'd9, 5'd0, 12'h123);
        prog[1] = enc_r(1'b0, 5'd10, 5'd9, 5'd9, 3'd0);
        prog[2] = enc_r(1'b1, 5'd11, 5'd10, 5'd9, 3'd0);
        prog[3] = 32'h0000_007f;
        prog[4] = enc_i(OP_IMM, 5'd12, 5'd0, 12'h0ff);
        load_program();
        hpc = run_model();
        start_core();
        wait_halt(hpc);
        apb_xfer(1'b0, `RV_MAP_CTRL, '0, rd, err);
        check("ctrl running", 32'd0, rd);
        compare_regs("halt");
        end_test("halt", e0);

        // apb protection while the countdown runs
        e0 = errors;
        build_countdown(12'd60);
        load_program();
        hpc = run_model();
        start_core();
        apb_xfer(1'b0, `RV_MAP_CTRL, '0, rd, err);
        check("ctrl running", 32'd1, rd);
        apb_xfer(1'b1, `RV_MAP_IMEM + 12'h014, 32'hdead_beef, rd, err);
        check("imem write pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b0, `RV_MAP_IMEM + 12'h014, '0, rd, err);
        check("imem read pslverr", 32'd1, {31'd0, err});
        check("imem read data", 32'd0, rd);
        apb_xfer(1'b1, `RV_MAP_DMEM + 12'h00c, 32'hcafe_f00d, rd, err);
        check("dmem write pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b0, `RV_MAP_DMEM + 12'h00c, '0, rd, err);
        check("dmem read pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b1, `RV_MAP_REGS + 12'h014, 32'h0000_5555, rd, err);
        check("regs write pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b0, 12'h008, '0, rd, err);
        check("unmapped pslverr", 32'd1, {31'd0, err});
        check("unmapped data", 32'd0, rd);
        apb_xfer(1'b0, 12'h400, '0, rd, err);
        check("unmapped pslverr", 32'd1, {31'd0, err});
        wait_halt(hpc);
        apb_xfer(1'b1, 12'h0f0, 32'd7, rd, err);
        check("unmapped pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b1, `RV_MAP_REGS + 12'h01c, 32'd7, rd, err);
        check("regs write pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b0, `RV_MAP_IMEM + 12'h014, '0, rd, err);
        check("imem[5]", prog[5], rd);
        apb_xfer(1'b0, `RV_MAP_DMEM + 12'h00c, '0, rd, err);
        check("dmem[3]", m_dmem[3], rd);
        compare_regs("prot");
        end_test("apb protection", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/rv_core_pkg.sv
hw/fetch_unit.sv
hw/if_id.sv
hw/exec_unit.sv
hw/apb_ctrl.sv
hw/rv_core_top.sv
dv/rv_core_properties.sv
dv/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the rv core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f vlog.f --top-module rv_core_tb \
    -o rv_core_sim > build.log 2>&1 &&
    ./obj_dir/rv_core_sim > sim.log 2>&1 ||
    { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log &&
    { echo "PASS"; exit 0; } ||
    { echo "FAIL"; exit 1; }
